/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module tb_alu_core \
		-Mdir obj_dir -o sim_alu_core

run: compile
	./obj_dir/sim_alu_core | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* alu_cfg.svh */
// ALU configuration
// Data width and the span of the accuracy-controllable adder
// The error mask covers the low ALU_APX_LEN adder bits

`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// --------------------------------------------------
// Datapath
// --------------------------------------------------
`define ALU_XLEN      32    // RV32I word

// --------------------------------------------------
// Approximate adder
// --------------------------------------------------
// Low bits under the error mask, keep it a multiple of the block width
`define ALU_APX_LEN   8

// One carry-select block
`define ALU_BLOCK_W   4     // Nibble, half adder plus 3 ripple bits

`endif

/* alu_core_top.sv */
// RV32I execute-stage ALU, top level
// Issue decode, approximate adder, shift/logic unit and the result register

`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_core_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  alu_types_pkg::alu_req_t req,
    input  alu_types_pkg::apx_csr_t csr,
    output logic                    out_valid,
    output alu_types_pkg::word_t    result,
    output logic                    illegal
);

    import alu_types_pkg::*;

    alu_op_t   op;
    word_t     operand_a;
    word_t     operand_b;
    logic      sub;
    err_mask_t mask;
    word_t     sum;
    word_t     logic_result;

    // Accurate mode forces every mask bit exact
    assign mask = csr.err_ctrl[`ALU_APX_LEN+1:2] | {`ALU_APX_LEN{~csr.approx}};

    alu_issue u_issue (
        .req       (req),
        .op        (op),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .sub       (sub)
    );

    apx_adder u_adder (
        .a    (operand_a),
        .b    (operand_b),
        .sub  (sub),
        .mask (mask),
        .sum  (sum)
    );

    alu_shift_logic u_shift_logic (
        .op        (op),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .result    (logic_result)
    );

    alu_result_stage u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .op           (op),
        .sum          (sum),
        .logic_result (logic_result),
        .out_valid    (out_valid),
        .illegal      (illegal),
        .result       (result)
    );

endmodule

/* alu_issue.sv */
// ALU issue logic
// Classifies opcode and funct fields into an ALU operation
// and steers PC, rs1, rs2, the immediate or 4 onto the two operands

`timescale 1ns/1ps

module alu_issue (
    input  alu_types_pkg::alu_req_t req,
    output alu_types_pkg::alu_op_t  op,
    output alu_types_pkg::word_t    operand_a,
    output alu_types_pkg::word_t    operand_b,
    output logic                    sub
);

    import rv_isa_pkg::*;
    import alu_types_pkg::*;

    // Base operation from funct3, alt picks SUB / SRA
    function automatic alu_op_t base_op(funct3_t f3, logic alt);
        alu_op_t o;
        case (f3)
            F3_ADD_SUB: o = alt ? SUB : ADD;
            F3_SLL:     o = SLL;
            F3_SLT:     o = SLT;
            F3_SLTU:    o = SLTU;
            F3_XOR:     o = XOR;
            F3_SRL_SRA: o = alt ? SRA : SRL;
            F3_OR:      o = OR;
            default:    o = AND;                        // F3_AND
        endcase
        return o;
    endfunction

    // --------------------------------------------------
    // Operand steering and operation decode
    // --------------------------------------------------
    always_comb begin
        operand_a = req.rs1;                            // Default R-type operands
        operand_b = req.rs2;
        op        = ILLEGAL;
        case (req.opcode)
            OP: begin
                if (req.funct7 == '0)
                    op = base_op(req.funct3, 1'b0);
                else if (req.funct7 == FUNCT7_ALT &&
                         (req.funct3 == F3_ADD_SUB || req.funct3 == F3_SRL_SRA))
                    op = base_op(req.funct3, 1'b1);     // SUB or SRA
            end
            OP_IMM: begin
                operand_b = req.imm;
                // Shift immediates carry funct7 in imm[11:5]
                if (req.funct3 == F3_SLL) begin
                    if (req.funct7 == '0)
                        op = SLL;
                end else if (req.funct3 == F3_SRL_SRA) begin
                    if (req.funct7 == '0)
                        op = SRL;
                    else if (req.funct7 == FUNCT7_ALT)
                        op = SRA;
                end else begin
                    op = base_op(req.funct3, 1'b0);     // No SUBI
                end
            end
            JAL, JALR: begin
                operand_a = req.pc;                     // Link address PC + 4
                operand_b = word_t'(4);
                if (req.opcode == JAL || req.funct3 == F3_ADD_SUB)
                    op = ADD;
            end
            AUIPC: begin
                operand_a = req.pc;
                operand_b = req.imm;                    // Upper immediate, already shifted
                op        = ADD;
            end
            default: ;                                  // Stays ILLEGAL
        endcase
    end

    assign sub = (op == SUB);                           // Adder inverts b, carry-in 1

    // Known request fields always decode to a known operation
    always_comb begin
        a_op_known: assert final ($isunknown(req) || !$isunknown(op))
            else $error("alu_issue: unknown op from known request");
    end

endmodule

/* alu_result_stage.sv */
// ALU result register
// Picks the adder or shift/logic result and registers it
// together with the valid and illegal flags, one cycle

`timescale 1ns/1ps

module alu_result_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  alu_types_pkg::alu_op_t op,
    input  alu_types_pkg::word_t   sum,
    input  alu_types_pkg::word_t   logic_result,
    output logic                   out_valid,
    output logic                   illegal,
    output alu_types_pkg::word_t   result
);

    import alu_types_pkg::*;

    word_t next_result;

    always_comb begin
        case (op)
            ADD, SUB: next_result = sum;                // Also jumps and AUIPC
            ILLEGAL:  next_result = '0;
            default:  next_result = logic_result;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            illegal   <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= in_valid;
            illegal   <= in_valid && (op == ILLEGAL);
            if (in_valid)
                result <= next_result;                  // Hold between instructions
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_illegal_zero: assert property (@(posedge clk) disable iff (!rst_n)
        illegal |-> result == '0)
        else $error("alu_result_stage: illegal with non-zero result");

    a_valid_follow: assert property (@(posedge clk) disable iff (!rst_n)
        1'b1 |=> out_valid == $past(in_valid))
        else $error("alu_result_stage: out_valid not one cycle after in_valid");

endmodule

/* alu_shift_logic.sv */
// Shift, compare and bitwise unit
// Everything except the adder operations, combinational

`timescale 1ns/1ps

module alu_shift_logic (
    input  alu_types_pkg::alu_op_t op,
    input  alu_types_pkg::word_t   operand_a,
    input  alu_types_pkg::word_t   operand_b,
    output alu_types_pkg::word_t   result
);

    import alu_types_pkg::*;

    shamt_t shamt;
    logic   lt_signed;
    logic   lt_unsigned;

    assign shamt       = operand_b[$bits(shamt_t)-1:0];     // Upper bits ignored
    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    // --------------------------------------------------
    // Result select
    // --------------------------------------------------
    always_comb begin
        case (op)
            SLL:     result = operand_a << shamt;
            SRL:     result = operand_a >> shamt;
            SRA:     result = word_t'($signed(operand_a) >>> shamt);    // Sign fill
            SLT:     result = word_t'(lt_signed);
            SLTU:    result = word_t'(lt_unsigned);
            XOR:     result = operand_a ^ operand_b;
            OR:      result = operand_a | operand_b;
            AND:     result = operand_a & operand_b;
            default: result = '0;                       // ADD, SUB, ILLEGAL
        endcase
    end

endmodule

/* alu_types_pkg.sv */
// ALU datapath types
// Word and mask types, the ALU operation, the request and the approximation CSR

`include "alu_cfg.svh"

package alu_types_pkg;

    typedef logic [`ALU_XLEN-1:0]         word_t;
    typedef logic [$clog2(`ALU_XLEN)-1:0] shamt_t;
    typedef logic [`ALU_APX_LEN-1:0]      err_mask_t;   // 1 = exact bit

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        ILLEGAL                                         // Unsupported encoding
    } alu_op_t;

    // Decoded instruction fields plus operands
    typedef struct packed {
        rv_isa_pkg::opcode_t opcode;
        rv_isa_pkg::funct3_t funct3;
        rv_isa_pkg::funct7_t funct7;
        word_t               pc;
        word_t               rs1;
        word_t               rs2;
        word_t               imm;
    } alu_req_t;

    // Approximation CSR, error control low 2 bits are the unused circuit select
    typedef struct packed {
        logic [`ALU_XLEN-`ALU_APX_LEN-4:0] rsvd;
        logic [`ALU_APX_LEN+1:0]           err_ctrl;    // Mask lives in [APX_LEN+1:2]
        logic                              approx;      // 1 = approximate mode
    } apx_csr_t;

    // Error-configurable full adder, returns {carry, sum}
    function automatic logic [1:0] ecfa(logic er, logic a, logic b, logic c);
        logic p;
        p = a ^ b;
        return {(er & b & c) | ((b | c) & a), ~(er & p & c) & (p | c)};
    endfunction

endpackage

/* apx_adder.sv */
// Accuracy-controllable adder
// Low nibble is an error-configurable ripple, the rest is a chain of
// carry-select blocks, approximate up to ALU_APX_LEN and exact above

`timescale 1ns/1ps
`include "alu_cfg.svh"

module apx_adder (
    input  alu_types_pkg::word_t     a,
    input  alu_types_pkg::word_t     b,
    input  logic                     sub,
    input  alu_types_pkg::err_mask_t mask,
    output alu_types_pkg::word_t     sum
);

    import alu_types_pkg::*;

    localparam int NBLK = `ALU_XLEN / `ALU_BLOCK_W;

    word_t           b_eff;
    word_t           mask_ext;                          // Exact above the masked span
    logic [NBLK-1:0] blk_carry;                         // Carry out of each block

    assign b_eff    = sub ? ~b : b;                     // Two's complement, carry-in below
    assign mask_ext = {{(`ALU_XLEN-`ALU_APX_LEN){1'b1}}, mask};

    // --------------------------------------------------
    // Low nibble, full ripple with carry-in
    // --------------------------------------------------
    always_comb begin
        logic       c;
        logic [1:0] fa;
        c = sub;
        for (int k = 0; k < `ALU_BLOCK_W; k++) begin
            fa     = ecfa(mask_ext[k], a[k], b_eff[k], c);
            sum[k] = fa[0];
            c      = fa[1];
        end
        blk_carry[0] = c;
    end

    // Upper blocks, bit base+0 is a half adder so its mask bit is skipped
    for (genvar g = 1; g < NBLK; g++) begin : g_blk
        localparam int BASE = g * `ALU_BLOCK_W;

        apx_adder_block #(
            .APPROX (BASE < `ALU_APX_LEN)
        ) u_blk (
            .a         (a[BASE +: `ALU_BLOCK_W]),
            .b         (b_eff[BASE +: `ALU_BLOCK_W]),
            .er        (mask_ext[BASE+1 +: `ALU_BLOCK_W-1]),
            .carry_in  (blk_carry[g-1]),
            .sum       (sum[BASE +: `ALU_BLOCK_W]),
            .carry_out (blk_carry[g])
        );
    end

endmodule

/* apx_adder_block.sv */
// Carry-select adder block
// Half adder plus ripple on the upper bits, exact or error-configurable,
// with an incrementer path chosen by the incoming carry

`timescale 1ns/1ps
`include "alu_cfg.svh"

module apx_adder_block #(
    parameter bit APPROX = 1'b0                         // 1 = ripple bits use er
) (
    input  logic [`ALU_BLOCK_W-1:0] a,
    input  logic [`ALU_BLOCK_W-1:0] b,
    input  logic [`ALU_BLOCK_W-2:0] er,                 // 1 = exact bit
    input  logic                    carry_in,
    output logic [`ALU_BLOCK_W-1:0] sum,
    output logic                    carry_out
);

    import alu_types_pkg::*;

    logic [`ALU_BLOCK_W-2:0] er_eff;
    logic [`ALU_BLOCK_W-1:0] rip_sum;                   // Nibble sum assuming carry 0
    logic                    rip_carry;
    logic [`ALU_BLOCK_W-1:0] inc_sum;                   // Nibble + 1
    logic                    inc_carry;

    // Exact blocks force every ripple bit exact
    assign er_eff = APPROX ? er : '1;

    // --------------------------------------------------
    // Half adder and ripple
    // --------------------------------------------------
    always_comb begin
        logic       c;
        logic [1:0] fa;
        rip_sum[0] = a[0] ^ b[0];                       // Half adder
        c          = a[0] & b[0];
        for (int k = 1; k < `ALU_BLOCK_W; k++) begin
            fa         = ecfa(er_eff[k-1], a[k], b[k], c);
            rip_sum[k] = fa[0];
            c          = fa[1];
        end
        rip_carry = c;
    end

    // Incrementer carries out only on an all-ones nibble
    assign {inc_carry, inc_sum} = {1'b0, rip_sum} + (`ALU_BLOCK_W+1)'(1);

    // Carry select
    always_comb begin
        if (carry_in) begin
            sum       = inc_sum;
            carry_out = rip_carry | inc_carry;
        end else begin
            sum       = rip_sum;
            carry_out = rip_carry;
        end
    end

endmodule

/* rv_isa_pkg.sv */
// RISC-V encoding definitions
// Opcodes served by the execute-stage ALU and the funct field types

package rv_isa_pkg;

    // Major opcodes, only the five this ALU executes
    typedef enum logic [6:0] {
        OP_IMM = 7'b00_100_11,  // I-type arithmetic
        AUIPC  = 7'b00_101_11,
        OP     = 7'b01_100_11,  // R-type arithmetic
        JALR   = 7'b11_001_11,
        JAL    = 7'b11_011_11
    } opcode_t;

    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // --------------------------------------------------
    // funct3 encodings for OP and OP_IMM
    // --------------------------------------------------
    localparam funct3_t F3_ADD_SUB = 3'b000;    // Also JALR
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct7 variant selecting SUB over ADD and SRA over SRL
    localparam funct7_t FUNCT7_ALT = 7'b0_100_000;

endpackage

/* sources.f */
+incdir+.
rv_isa_pkg.sv
alu_types_pkg.sv
alu_issue.sv
apx_adder_block.sv
apx_adder.sv
alu_shift_logic.sv
alu_result_stage.sv
alu_core_top.sv
tb_alu_core.sv

/* tb_alu_core.sv */
// Testbench for the RV32I execute-stage ALU
// LFSR stimulus per instruction class, a bit-level reference model,
// and concurrent assertions that compare each output one cycle later

`timescale 1ns/1ps
`include "alu_cfg.svh"

module tb_alu_core;

    import rv_isa_pkg::*;
    import alu_types_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int N_PER_GROUP  = 16;
    localparam int N_GROUPS     = 29;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + N_PER_GROUP * N_GROUPS + 50;
    localparam int HI_W         = `ALU_XLEN - `ALU_APX_LEN;    // Exact upper span

    typedef struct packed {
        logic  valid;
        logic  illegal;
        word_t result;
    } exp_t;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     in_valid;
    alu_req_t req;
    apx_csr_t csr;
    logic     out_valid;
    word_t    result;
    logic     illegal;

    exp_t        exp_q[$];                              // One-deep queue filled by the driver
    string       name_q[$];
    exp_t        chk = '0;                              // Expected for the current output
    string       chk_name = "none";
    logic        started = 1'b0;
    logic [31:0] lfsr_state = 32'hec92;
    int          vec_count = 0;
    int          checked_count = 0;
    int          cycle_count = 0;

    alu_core_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .req       (req),
        .csr       (csr),
        .out_valid (out_valid),
        .result    (result),
        .illegal   (illegal)
    );

    always #2 clk = ~clk;                               // 4 ns period

    // --------------------------------------------------
    // Failure reporting
    // --------------------------------------------------
    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(string name, word_t expected, word_t actual);
        $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        abort_run();
    endtask

    // --------------------------------------------------
    // Stimulus source
    // --------------------------------------------------
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(int n);  // One step per bit
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic logic [1:0] fa_model(logic er, logic x, logic y, logic ci);
        if (er)
            return {(x & y) | (x & ci) | (y & ci), x ^ y ^ ci};
        return {x & (y | ci), (x ^ y) | ci};            // Error mode
    endfunction

    function automatic word_t apx_sum(word_t a, word_t b, logic sub, err_mask_t m);
        word_t       bb;
        word_t       s;
        logic        c;
        logic        cn;
        logic [1:0]  fa;
        logic [3:0]  nib;
        logic [4:0]  inc;
        logic [HI_W:0] hi;
        if (&m)
            return sub ? a - b : a + b;                 // Every bit exact
        bb = sub ? ~b : b;
        c  = sub;
        for (int k = 0; k < 4; k++) begin               // Low nibble as a full ripple
            fa   = fa_model(m[k], a[k], bb[k], c);
            s[k] = fa[0];
            c    = fa[1];
        end
        for (int base = 4; base < `ALU_APX_LEN; base += 4) begin
            nib[0] = a[base] ^ bb[base];                // Half adder ignores its mask bit
            cn     = a[base] & bb[base];
            for (int k = 1; k < 4; k++) begin
                fa     = fa_model(m[base+k], a[base+k], bb[base+k], cn);
                nib[k] = fa[0];
                cn     = fa[1];
            end
            inc = {1'b0, nib} + 5'd1;
            if (c) begin                                // Incremented nibble selected
                nib = inc[3:0];
                cn  = cn | inc[4];
            end
            s[base +: 4] = nib;
            c            = cn;
        end
        hi = {1'b0, a[`ALU_XLEN-1:`ALU_APX_LEN]} + {1'b0, bb[`ALU_XLEN-1:`ALU_APX_LEN]}
             + {{HI_W{1'b0}}, c};
        s[`ALU_XLEN-1:`ALU_APX_LEN] = hi[HI_W-1:0];
        return s;
    endfunction

    function automatic exp_t model(alu_req_t r, apx_csr_t c);
        exp_t        e;
        word_t       a;
        word_t       b;
        logic [31:0] cw;
        err_mask_t   m;
        logic        alt;
        logic        bad;
        cw  = c;
        m   = cw[0] ? cw[10:3] : '1;                   // Accurate mode is all exact
        a   = r.rs1;
        b   = r.rs2;
        alt = (r.funct7 == 7'h20);
        bad = 1'b0;
        case (r.opcode)
            OP: bad = (r.funct7 != '0) && !(alt && (r.funct3 == 3'd0 || r.funct3 == 3'd5));
            OP_IMM: begin
                b   = r.imm;
                bad = (r.funct3 == 3'd1 || r.funct3 == 3'd5) && r.funct7 != '0
                      && !(alt && r.funct3 == 3'd5);
                alt = alt && (r.funct3 == 3'd5);        // No SUBI
            end
            JAL, JALR: begin
                a   = r.pc;
                b   = 32'd4;
                bad = (r.opcode == JALR) && (r.funct3 != 3'd0);
            end
            AUIPC: begin
                a = r.pc;
                b = r.imm;
            end
            default: bad = 1'b1;
        endcase
        e.valid   = 1'b1;
        e.illegal = bad;
        e.result  = '0;
        if (!bad && r.opcode != OP && r.opcode != OP_IMM)
            e.result = apx_sum(a, b, 1'b0, m);
        else if (!bad) begin
            case (r.funct3)
                3'd0:    e.result = apx_sum(a, b, alt, m);
                3'd1:    e.result = a << b[4:0];
                3'd2:    e.result = {31'd0, $signed(a) < $signed(b)};
                3'd3:    e.result = {31'd0, a < b};
                3'd4:    e.result = a ^ b;
                3'd5:    e.result = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'd6:    e.result = a | b;
                default: e.result = a & b;
            endcase
        end
        return e;
    endfunction

    // --------------------------------------------------
    // Driver
    // --------------------------------------------------
    task automatic send(string name, alu_req_t r, apx_csr_t c);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        req      = r;
        csr      = c;
        exp_q.push_back(model(r, c));
        name_q.push_back(name);
        vec_count++;
    endtask

    task automatic go_idle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // Back-to-back vectors of one encoding, then one idle cycle
    task automatic run_group(string name, logic [6:0] opc, funct3_t f3, funct7_t f7,
                             logic approx, logic full_mask, logic neg_a);
        alu_req_t    r;
        logic [31:0] cw;
        for (int i = 0; i < N_PER_GROUP; i++) begin
            r.opcode = opcode_t'(opc);
            r.funct3 = f3;
            r.funct7 = f7;
            r.pc     = take_bits(32);
            r.rs1    = take_bits(32);
            r.rs2    = take_bits(32);
            r.imm    = take_bits(32);
            if (neg_a)
                r.rs1[31] = 1'b1;                       // Sign-fill paths
            cw    = take_bits(32);
            cw[0] = approx;
            if (full_mask)
                cw[10:3] = 8'hff;
            send(name, r, apx_csr_t'(cw));
        end
        go_idle();
    endtask

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    always @(posedge clk) begin
        if (exp_q.size() != 0) begin
            chk      <= exp_q.pop_front();
            chk_name <= name_q.pop_front();
            started  <= 1'b1;
        end else begin
            chk <= '0;
        end
    end

    always @(negedge clk)
        if (rst_n && chk.valid && out_valid)
            checked_count++;

    a_idle_after_reset: assert property (@(negedge clk) disable iff (!rst_n)
        !started |-> (!out_valid && !illegal && result == '0))
        else begin
            $display("ERROR: outputs not idle after reset, out_valid %b illegal %b result %h",
                     out_valid, illegal, result);
            abort_run();
        end

    a_valid_match: assert property (@(negedge clk) disable iff (!rst_n)
        out_valid == chk.valid)
        else report_mismatch({chk_name, " out_valid"}, word_t'(chk.valid), word_t'(out_valid));

    a_illegal_match: assert property (@(negedge clk) disable iff (!rst_n)
        illegal == chk.illegal)
        else report_mismatch({chk_name, " illegal"}, word_t'(chk.illegal), word_t'(illegal));

    a_result_match: assert property (@(negedge clk) disable iff (!rst_n)
        chk.valid |-> result == chk.result)
        else report_mismatch(chk_name, chk.result, result);

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("TIMEOUT: run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        req      = '0;
        csr      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (2) @(posedge clk);                      // Idle outputs after reset

        // Accurate mode with random error bits
        run_group("add_exact",  OP,     3'd0, 7'h00, 1'b0, 1'b0, 1'b0);
        run_group("sub_exact",  OP,     3'd0, 7'h20, 1'b0, 1'b0, 1'b0);
        run_group("addi_exact", OP_IMM, 3'd0, 7'h15, 1'b0, 1'b0, 1'b0);
        run_group("jal_link",   JAL,    3'd5, 7'h00, 1'b0, 1'b0, 1'b0);
        run_group("jalr_link",  JALR,   3'd0, 7'h00, 1'b0, 1'b0, 1'b0);
        run_group("auipc",      AUIPC,  3'd0, 7'h00, 1'b0, 1'b0, 1'b0);

        // Shift, compare and bitwise ops in R and I form with negative rs1 for SLT
        for (int f = 1; f < 8; f++) begin
            run_group($sformatf("op_f3_%0d", f), OP, funct3_t'(f), 7'h00,
                      1'b0, 1'b0, f == 2);
            run_group($sformatf("op_imm_f3_%0d", f), OP_IMM, funct3_t'(f),
                      (f == 1 || f == 5) ? 7'h00 : 7'h2a, 1'b0, 1'b0, f == 2);
        end
        run_group("sra_neg",  OP,     3'd5, 7'h20, 1'b0, 1'b0, 1'b1);
        run_group("srai_neg", OP_IMM, 3'd5, 7'h20, 1'b0, 1'b0, 1'b1);

        // Approximate mode
        run_group("add_apx_full_mask", OP, 3'd0, 7'h00, 1'b1, 1'b1, 1'b0);
        run_group("sub_apx_full_mask", OP, 3'd0, 7'h20, 1'b1, 1'b1, 1'b0);
        run_group("add_apx_rand_mask", OP, 3'd0, 7'h00, 1'b1, 1'b0, 1'b0);
        run_group("sub_apx_rand_mask", OP, 3'd0, 7'h20, 1'b1, 1'b0, 1'b0);

        // Illegal encodings
        run_group("unknown_opcode",  7'b000_0011, 3'd0, 7'h00, 1'b0, 1'b0, 1'b0);
        run_group("op_bad_funct7",   OP,          3'd0, 7'h01, 1'b0, 1'b0, 1'b0);
        run_group("jalr_bad_funct3", JALR,        3'd2, 7'h00, 1'b0, 1'b0, 1'b0);

        repeat (2) @(posedge clk);                      // Drain the last output
        if (checked_count == vec_count) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("ERROR: only %0d of %0d vectors were checked", checked_count, vec_count);
            abort_run();
        end
    end

endmodule
